// File: a2bus_if.sv
// ====================================================================
// Apple II bus signals seen by the scanline timer
// The testbench drives the master side, the design snoops the slave side
// ====================================================================

`timescale 1ns/1ns
`default_nettype none

interface a2bus_if;

    // Bus logic clock, the only clock in the design
    logic                   clk_logic;
    logic [15:0]            addr;
    scan_timer_pkg::bus_data_t data;
    // High for a read
    logic                   rw_n;
    // Single-cycle strobe, addr and data valid with it
    logic                   data_in_strobe;
    // Low when the Mega II is selected
    logic                   m2sel_n;
    // Long bus cycle at the end of every scanline
    logic                   extended_cycle;

    modport slave (
        input clk_logic, addr, data, rw_n, data_in_strobe, m2sel_n, extended_cycle
    );

    modport master (
        output clk_logic, addr, data, rw_n, data_in_strobe, m2sel_n, extended_cycle
    );

endinterface

`default_nettype wire

// File: flist.f
scan_timer_pkg.sv
a2bus_if.sv
scan_bus_decode.sv
scan_resync_detect.sv
scan_line_counter.sv
scan_timer.sv
scan_timer_assertions.sv
tb_scan_timer.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the scanline timer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_scan_timer -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_scan_timer)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
exit 1

// File: scan_bus_decode.sv
// ====================================================================
// Bus snoop stage, registers reads of $C02E and $C019 into a record
// One cycle from bus strobe to snoop record
// ====================================================================

`timescale 1ns/1ns
`default_nettype none

module scan_bus_decode (
    a2bus_if.slave                  bus,
    input  logic                    rst_n_i,
    output scan_timer_pkg::snoop_t  snoop_o
);

    import scan_timer_pkg::*;

    logic      rd_qual;
    logic      vertcnt_hit;
    logic      vbl_hit;
    logic      vertcnt_rd_q;
    logic      vbl_rd_q;
    bus_data_t data_q;

    // Read of a Mega II register in this cycle
    assign rd_qual     = bus.data_in_strobe && bus.rw_n && !bus.m2sel_n;
    assign vertcnt_hit = rd_qual && (bus.addr == VERTCNT_ADDR);
    assign vbl_hit     = rd_qual && (bus.addr == VBL_ADDR);

    // Flags are one-cycle strobes
    always_ff @(posedge bus.clk_logic or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vertcnt_rd_q <= 1'b0;
            vbl_rd_q     <= 1'b0;
        end else begin
            vertcnt_rd_q <= vertcnt_hit;
            vbl_rd_q     <= vbl_hit;
        end
    end

    // Byte only meaningful alongside a flag
    always_ff @(posedge bus.clk_logic) begin
        if (vertcnt_hit || vbl_hit) begin
            data_q <= bus.data;
        end
    end

    assign snoop_o = '{vertcnt_rd: vertcnt_rd_q, vbl_rd: vbl_rd_q, data: data_q};

endmodule

`default_nettype wire

// File: scan_line_counter.sv
// ====================================================================
// Scanline ring counter with pixel counter, sync pulses and resync
// Advances on each line end, jumps when the drift is beyond threshold
// ====================================================================

`timescale 1ns/1ns
`default_nettype none

module scan_line_counter (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic                      line_end_i,
    input  scan_timer_pkg::resync_t   resync_i,
    output scan_timer_pkg::scanline_t scanline_o,
    output scan_timer_pkg::pixel_t    pixel_o,
    output logic                      hsync_o,
    output logic                      vsync_o
);

    import scan_timer_pkg::*;

    scanline_t line_q;
    pixel_t    pixel_q;
    logic      hsync_q;
    logic      vsync_q;
    scanline_t drift;
    logic      apply_resync;
    logic      at_last_line;

    // Shorter way round the ring between two lines, 0..131
    function automatic scanline_t ring_dist(input scanline_t a, input scanline_t b);
        scanline_t fwd;
        scanline_t rev;
        if (a <= b) begin
            fwd = b - a;
        end else begin
            fwd = LINES_PER_FRAME - a + b;
        end
        rev = LINES_PER_FRAME - fwd;
        return (fwd <= rev) ? fwd : rev;
    endfunction

    // Drift measured before this cycle's advance
    assign drift        = ring_dist(line_q, resync_i.line);
    assign apply_resync = resync_i.valid && (drift > RESYNC_THRESHOLD);
    assign at_last_line = (line_q == LAST_LINE);

    // ================================================================
    // Counters
    // ================================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            line_q  <= RESET_LINE;
            pixel_q <= '0;
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
        end else begin
            // Sync pulses follow the line end by one cycle
            hsync_q <= line_end_i;
            // No frame start when a correction replaces the wrap
            vsync_q <= line_end_i && at_last_line && !apply_resync;

            // Pixel count restarts each line, holds at the top
            if (line_end_i) begin
                pixel_q <= '0;
            end else if (pixel_q != '1) begin
                pixel_q <= pixel_q + 1'b1;
            end

            // A correction overrides the normal advance
            if (apply_resync) begin
                line_q <= resync_i.line;
            end else if (line_end_i) begin
                line_q <= at_last_line ? '0 : line_q + 1'b1;
            end
        end
    end

    assign scanline_o = line_q;
    assign pixel_o    = pixel_q;
    assign hsync_o    = hsync_q;
    assign vsync_o    = vsync_q;

endmodule

`default_nettype wire

// File: scan_resync_detect.sv
// ====================================================================
// Turns snoop records into expected-line requests
// Vertical count conversion and tight-poll VBL edge detection
// ====================================================================

`timescale 1ns/1ns
`default_nettype none

module scan_resync_detect (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  scan_timer_pkg::snoop_t  snoop_i,
    output scan_timer_pkg::resync_t resync_o
);

    import scan_timer_pkg::*;

    scanline_t vertcnt_line;
    logic      vbl_active;
    logic      tight_poll;
    logic      vbl_edge;
    scanline_t vbl_line;
    gap_t      gap_q;
    logic      vbl_prev_q;
    logic      vbl_valid_q;
    logic      valid_q;
    scanline_t line_q;

    // ================================================================
    // Vertical count path
    // ================================================================

    // $C02E holds the top eight bits of the nine-bit hardware count,
    // so the line is known to within two
    always_comb begin
        if (snoop_i.data >= VERTCNT_HIGH_HALF) begin
            // Hardware $100..$1FF is line 0 onward
            vertcnt_line = {1'b0, snoop_i.data[6:0], 1'b0};
        end else begin
            // Hardware $0FA..$0FF sits at the end of the frame
            vertcnt_line = {snoop_i.data, 1'b0} + VERTCNT_WRAP_ADD;
        end
    end

    // ================================================================
    // VBL status path
    // ================================================================

    // IIgs polarity, bit 7 high during blanking
    assign vbl_active = snoop_i.data[7];
    assign tight_poll = (gap_q <= TIGHT_POLL_MAX);

    // Only a change seen between two close reads pins the edge down
    assign vbl_edge = snoop_i.vbl_rd && vbl_valid_q && tight_poll &&
                      (vbl_active != vbl_prev_q);

    // Rising bit enters blanking, falling bit starts the visible area
    assign vbl_line = vbl_active ? VBL_START_LINE : '0;

    // Gap timer and VBL history
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gap_q       <= GAP_MAX;
            vbl_prev_q  <= 1'b0;
            vbl_valid_q <= 1'b0;
        end else if (snoop_i.vbl_rd) begin
            gap_q       <= '0;
            vbl_prev_q  <= vbl_active;
            vbl_valid_q <= 1'b1;
        end else if (gap_q != GAP_MAX) begin
            gap_q <= gap_q + 1'b1;
        end
    end

    // ================================================================
    // Request register
    // ================================================================

    // One record per cycle, so the two paths never collide
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= snoop_i.vertcnt_rd || vbl_edge;
        end
    end

    always_ff @(posedge clk_i) begin
        if (snoop_i.vertcnt_rd) begin
            line_q <= vertcnt_line;
        end else if (vbl_edge) begin
            line_q <= vbl_line;
        end
    end

    assign resync_o = '{valid: valid_q, line: line_q};

endmodule

`default_nettype wire

// File: scan_timer.sv
// ====================================================================
// Apple II scanline timer top, bus snoop to resync to line counter
// ====================================================================

`timescale 1ns/1ns
`default_nettype none

module scan_timer (
    a2bus_if.slave                    a2bus_if,
    input  logic                      rst_n_i,
    output scan_timer_pkg::scanline_t scanline_o,
    output scan_timer_pkg::pixel_t    pixel_o,
    output logic                      hsync_o,
    output logic                      vsync_o
);

    import scan_timer_pkg::*;

    snoop_t  snoop;
    resync_t resync;

    // Qualified register reads, one cycle after the strobe
    scan_bus_decode u_bus_decode (
        .bus     (a2bus_if),
        .rst_n_i (rst_n_i),
        .snoop_o (snoop)
    );

    // Expected line, two cycles after the strobe
    scan_resync_detect u_resync_detect (
        .clk_i    (a2bus_if.clk_logic),
        .rst_n_i  (rst_n_i),
        .snoop_i  (snoop),
        .resync_o (resync)
    );

    scan_line_counter u_line_counter (
        .clk_i      (a2bus_if.clk_logic),
        .rst_n_i    (rst_n_i),
        .line_end_i (a2bus_if.extended_cycle),
        .resync_i   (resync),
        .scanline_o (scanline_o),
        .pixel_o    (pixel_o),
        .hsync_o    (hsync_o),
        .vsync_o    (vsync_o)
    );

endmodule

`default_nettype wire

// File: scan_timer_assertions.sv
// ====================================================================
// Concurrent checks on the line counter, bound into every instance
// ====================================================================

`timescale 1ns/1ns
`default_nettype none

module scan_timer_assertions (
    input logic                      clk_i,
    input logic                      rst_n_i,
    input logic                      hsync_i,
    input logic                      vsync_i,
    input scan_timer_pkg::scanline_t scanline_i
);

    import scan_timer_pkg::*;

    // Sync pulses are one cycle wide
    hsync_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        hsync_i |=> !hsync_i) else $error("hsync held for more than one cycle");

    vsync_single: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        vsync_i |=> !vsync_i) else $error("vsync held for more than one cycle");

    // Frame start is always a line start
    vsync_with_hsync: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        vsync_i |-> hsync_i) else $error("vsync without hsync");

    line_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        scanline_i <= LAST_LINE) else $error("scanline beyond the last line");

endmodule

bind scan_line_counter scan_timer_assertions u_assertions (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .hsync_i    (hsync_o),
    .vsync_i    (vsync_o),
    .scanline_i (scanline_o)
);

`default_nettype wire

// File: scan_timer_pkg.sv
// ====================================================================
// Shared types and constants for the Apple II scanline timer
// Imported by every RTL stage of the timer
// ====================================================================

`default_nettype none

package scan_timer_pkg;

    // ================================================================
    // Vector types
    // ================================================================

    // Line number on the 262-line ring
    typedef logic [8:0]  scanline_t;
    // Logic clocks since the last line end
    typedef logic [9:0]  pixel_t;
    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;
    // Logic clocks since the last VBL status read
    typedef logic [9:0]  gap_t;

    // One registered bus snoop, at most one flag set
    typedef struct packed {
        logic      vertcnt_rd;
        logic      vbl_rd;
        bus_data_t data;
    } snoop_t;

    // Expected line from either resync path
    typedef struct packed {
        logic      valid;
        scanline_t line;
    } resync_t;

    // ================================================================
    // Frame geometry
    // ================================================================

    localparam scanline_t LINES_PER_FRAME = 9'd262;
    localparam scanline_t LAST_LINE       = 9'd261;
    // First blanking line after the visible area
    localparam scanline_t VBL_START_LINE  = 9'd192;
    // Six blanking lines before visible line 0, like the Mega II at $0FA
    localparam scanline_t RESET_LINE      = 9'd256;

    // ================================================================
    // Soft-switch registers
    // ================================================================

    localparam bus_addr_t VERTCNT_ADDR      = 16'hC02E;
    localparam bus_addr_t VBL_ADDR          = 16'hC019;
    // Upper half of the hardware count maps straight onto lines 0..255
    localparam bus_data_t VERTCNT_HIGH_HALF = 8'h80;
    // Lower half covers the tail of the frame
    localparam scanline_t VERTCNT_WRAP_ADD  = 9'd6;

    // ================================================================
    // Resync limits
    // ================================================================

    // Roughly an eight cycle polling loop with margin
    localparam gap_t      TIGHT_POLL_MAX   = 10'd600;
    localparam gap_t      GAP_MAX          = 10'd1023;
    localparam scanline_t RESYNC_THRESHOLD = 9'd2;

endpackage

`default_nettype wire

// File: tb_scan_timer.sv
// ====================================================================
// Directed and random testbench for the Apple II scanline timer
// Drives the bus interface and checks line, pixel and sync outputs
// ====================================================================

`timescale 1ns/1ns
`default_nettype none

module tb_scan_timer;

    import scan_timer_pkg::*;

    // Longest run is near 4000 cycles, five times that as a margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RANDOM_READS   = 30;

    logic      clk;
    logic      rst_n;
    scanline_t scanline;
    pixel_t    pixel;
    logic      hsync;
    logic      vsync;
    // Reference line model
    scanline_t ref_line;
    int        error_count;
    int        check_count;
    int        cycle_count;
    int unsigned seed_val;

    a2bus_if bus_if ();

    assign bus_if.clk_logic = clk;

    scan_timer DUT (
        .a2bus_if   (bus_if),
        .rst_n_i    (rst_n),
        .scanline_o (scanline),
        .pixel_o    (pixel),
        .hsync_o    (hsync),
        .vsync_o    (vsync)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("ERROR: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ================================================================
    // Reference rules and compare tasks
    // ================================================================

    // Shorter way round the 262-line ring
    function automatic int ring_gap(input scanline_t from, input scanline_t to);
        int diff;
        diff = (int'(to) - int'(from) + int'(LINES_PER_FRAME)) % int'(LINES_PER_FRAME);
        if (diff > int'(LINES_PER_FRAME) / 2) begin
            diff = int'(LINES_PER_FRAME) - diff;
        end
        return diff;
    endfunction

    // Upper half maps to 2*(low seven bits), lower half to 2*byte+6
    function automatic scanline_t vertcnt_to_line(input bus_data_t b);
        int v;
        if (b >= 8'h80) begin
            v = int'(b[6:0]) * 2;
        end else begin
            v = int'(b) * 2 + 6;
        end
        return scanline_t'(v);
    endfunction

    task automatic check_line(input scanline_t got, input scanline_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t ns: %s, line %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t ns: %s, pixel %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_sync(input logic got, input logic exp, input string what);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ================================================================
    // Bus driver tasks
    // ================================================================

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
    endtask

    // One strobe cycle, then back to an idle bus
    task automatic bus_cycle(input bus_addr_t a, input bus_data_t d, input logic rw_n,
                             input logic sel_n);
        @(posedge clk);
        bus_if.addr           <= a;
        bus_if.data           <= d;
        bus_if.rw_n           <= rw_n;
        bus_if.m2sel_n        <= sel_n;
        bus_if.data_in_strobe <= 1'b1;
        @(posedge clk);
        bus_if.data_in_strobe <= 1'b0;
        bus_if.m2sel_n        <= 1'b1;
    endtask

    task automatic bus_read(input bus_addr_t a, input bus_data_t d);
        bus_cycle(a, d, 1'b1, 1'b0);
    endtask

    task automatic line_end();
        @(posedge clk);
        bus_if.extended_cycle <= 1'b1;
        @(posedge clk);
        bus_if.extended_cycle <= 1'b0;
    endtask

    // Line end plus model update and sync checks
    task automatic advance_line();
        logic wrap;
        line_end();
        @(negedge clk);
        wrap     = (ref_line == LAST_LINE);
        ref_line = scanline_t'((int'(ref_line) + 1) % int'(LINES_PER_FRAME));
        check_line(scanline, ref_line, "line after line end");
        check_pixel(pixel, pixel_t'(0), "pixel after line end");
        check_sync(hsync, 1'b1, "hsync on line end");
        check_sync(vsync, wrap, "vsync on line end");
    endtask

    // Correction shows three cycles after the strobe
    task automatic vertcnt_read_check(input bus_data_t b);
        scanline_t exp_line;
        exp_line = vertcnt_to_line(b);
        bus_read(VERTCNT_ADDR, b);
        wait_cycles(2);
        @(negedge clk);
        if (ring_gap(ref_line, exp_line) > int'(RESYNC_THRESHOLD)) begin
            ref_line = exp_line;
        end
        check_line(scanline, ref_line, $sformatf("vertcnt byte %02h", b));
    endtask

    task automatic vbl_read_check(input int gap, input bus_data_t d, input scanline_t exp,
                                  input string what);
        wait_cycles(gap);
        bus_read(VBL_ADDR, d);
        wait_cycles(2);
        @(negedge clk);
        ref_line = exp;
        check_line(scanline, ref_line, what);
    endtask

    // ================================================================
    // Directed tests
    // ================================================================

    task automatic reset_and_wrap();
        check_line(scanline, RESET_LINE, "line after reset");
        check_pixel(pixel, pixel_t'(0), "pixel after reset");
        ref_line = RESET_LINE;
        // Lines 257..261 then the wrap to 0
        repeat (6) advance_line();
    endtask

    task automatic pixel_count();
        advance_line();
        for (int i = 1; i <= 5; i++) begin
            @(negedge clk);
            check_pixel(pixel, pixel_t'(i), "pixel count");
        end
        wait_cycles(1100);
        @(negedge clk);
        check_pixel(pixel, pixel_t'(1023), "pixel saturation");
        advance_line();
    endtask

    task automatic vertcnt_resync_directed();
        bus_data_t bytes[7] = '{8'h81, 8'h82, 8'h90, 8'h10, 8'h7F, 8'h7E, 8'hFE};
        foreach (bytes[i]) begin
            vertcnt_read_check(bytes[i]);
        end
        // Write and deselected read must not move the line
        bus_cycle(VERTCNT_ADDR, 8'hC0, 1'b0, 1'b0);
        wait_cycles(2);
        @(negedge clk);
        check_line(scanline, ref_line, "vertcnt write ignored");
        bus_cycle(VERTCNT_ADDR, 8'hC0, 1'b1, 1'b1);
        wait_cycles(2);
        @(negedge clk);
        check_line(scanline, ref_line, "vertcnt read without select ignored");
    endtask

    task automatic vbl_edge_resync();
        apply_reset();
        ref_line = RESET_LINE;
        // First read only primes the history
        vbl_read_check(2, 8'h80, RESET_LINE, "first VBL read after reset");
        vbl_read_check(100, 8'h00, scanline_t'(0), "VBL falling edge");
        vbl_read_check(100, 8'h80, VBL_START_LINE, "VBL rising edge");
        // Gap too long for a tight poll
        vbl_read_check(800, 8'h00, VBL_START_LINE, "VBL edge with wide gap");
    endtask

    task automatic vertcnt_resync_random();
        int n;
        for (int i = 0; i < RANDOM_READS; i++) begin
            n = int'($urandom % 41);
            repeat (n) advance_line();
            vertcnt_read_check(bus_data_t'($urandom));
        end
    endtask

    initial begin
        seed_val                 = $urandom(20);
        error_count              = 0;
        check_count              = 0;
        cycle_count              = 0;
        rst_n                    = 1'b0;
        bus_if.addr              = '0;
        bus_if.data              = '0;
        bus_if.rw_n              = 1'b1;
        bus_if.data_in_strobe    = 1'b0;
        bus_if.m2sel_n           = 1'b1;
        bus_if.extended_cycle    = 1'b0;
        apply_reset();
        reset_and_wrap();
        pixel_count();
        vertcnt_resync_directed();
        vbl_edge_resync();
        vertcnt_resync_random();
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
